/* common/brisc_params.svh */
`ifndef BRISC_PARAMS_SVH
`define BRISC_PARAMS_SVH

// datapath width
`define BRISC_XLEN 32

// architectural register count
`define BRISC_NREGS 32

// major opcode field width
`define BRISC_OPCODE_WIDTH 7

// fetch address after reset
`define BRISC_RESET_PC 0

`endif

/* common/brisc_pkg.sv */
`default_nettype none

`include "brisc_params.svh"

package brisc_pkg;

    // major opcodes of the supported subset
    typedef enum logic [`BRISC_OPCODE_WIDTH-1:0] {
        OPCODE_LOAD  = 7'b0000011,
        OPCODE_STORE = 7'b0100011,
        OPCODE_R     = 7'b0110011,
        OPCODE_IMM   = 7'b0010011,
        OPCODE_BEQ   = 7'b1100011,
        OPCODE_JUMP  = 7'b1101111
    } opcode_e;

    // alu class, resolved further by funct3/funct7
    typedef enum logic [1:0] {
        ADD_OP,
        SUB_OP,
        RTYPE_OP
    } alu_op_e;

    typedef enum logic [1:0] {
        ADD,
        SUB,
        OR,
        AND
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        I_IMM,
        S_IMM,
        B_IMM,
        J_IMM
    } imm_src_e;

    typedef enum logic {
        FROM_RS2,
        FROM_IMM
    } alu_src_e;

    // write-back source
    typedef enum logic [1:0] {
        FROM_ALU,
        FROM_MEM,
        FROM_PC_NEXT
    } result_src_e;

    typedef enum logic {
        B,
        W
    } data_size_e;

    typedef enum logic {
        NO_XCPT,
        UNDEF_INSTR
    } xcpt_e;

endpackage

`default_nettype wire

/* common/ctrl_if.sv */
`default_nettype none

interface ctrl_if;
    import brisc_pkg::*;

    logic        reg_write;
    imm_src_e    imm_src;
    result_src_e result_src;
    alu_src_e    alu_src;
    alu_ctrl_e   alu_ctrl;
    data_size_e  data_size;
    logic        mem_write;
    logic        is_branch;
    logic        is_jump;
    xcpt_e       xcpt;

    modport dec (
        output reg_write, imm_src, result_src, alu_src, alu_ctrl,
        output data_size, mem_write, is_branch, is_jump, xcpt
    );

    modport exe (
        input imm_src, alu_src, alu_ctrl
    );

    // next-pc selection and halt
    modport seq (
        input is_branch, is_jump, xcpt
    );

    modport mem (
        input data_size, mem_write, reg_write, result_src
    );

endinterface

`default_nettype wire

/* core/ctrl.sv */
`default_nettype none

module ctrl (
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    input  brisc_pkg::opcode_e opcode,
    ctrl_if.dec               ctl
);
    import brisc_pkg::*;

    alu_op_e alu_op;

    always_comb begin
        ctl.reg_write  = 1'b0;
        ctl.imm_src    = I_IMM;
        ctl.result_src = FROM_ALU;
        ctl.alu_src    = FROM_RS2;
        ctl.data_size  = W;
        ctl.mem_write  = 1'b0;
        ctl.is_branch  = 1'b0;
        ctl.is_jump    = 1'b0;
        ctl.xcpt       = NO_XCPT;
        alu_op         = ADD_OP;

        case (opcode)
            OPCODE_LOAD, OPCODE_STORE: begin
                ctl.alu_src = FROM_IMM;
                if (opcode == OPCODE_LOAD) begin
                    ctl.reg_write  = 1'b1;
                    ctl.result_src = FROM_MEM;
                end else begin
                    ctl.imm_src   = S_IMM;
                    ctl.mem_write = 1'b1;
                end
                // only byte and word widths exist here
                case (funct3)
                    3'b000:  ctl.data_size = B;
                    3'b010:  ctl.data_size = W;
                    default: ctl.xcpt = UNDEF_INSTR;
                endcase
            end
            OPCODE_R: begin
                ctl.reg_write = 1'b1;
                alu_op        = RTYPE_OP;
            end
            OPCODE_IMM: begin
                ctl.reg_write = 1'b1;
                ctl.alu_src   = FROM_IMM;
                alu_op        = RTYPE_OP;
            end
            OPCODE_BEQ: begin
                ctl.imm_src   = B_IMM;
                ctl.is_branch = 1'b1;
                alu_op        = SUB_OP;
                // other branch conditions are not implemented
                if (funct3 != 3'b000) begin
                    ctl.xcpt = UNDEF_INSTR;
                end
            end
            OPCODE_JUMP: begin
                ctl.reg_write  = 1'b1;
                ctl.imm_src    = J_IMM;
                ctl.result_src = FROM_PC_NEXT;
                ctl.is_jump    = 1'b1;
            end
            default: begin
                ctl.xcpt = UNDEF_INSTR;
            end
        endcase

        ctl.alu_ctrl = ADD;
        case (alu_op)
            SUB_OP: begin
                ctl.alu_ctrl = SUB;
            end
            RTYPE_OP: begin
                case (funct3)
                    // funct7[5] is an immediate bit for ADDI
                    3'b000:  ctl.alu_ctrl = (opcode == OPCODE_R && funct7[5]) ? SUB : ADD;
                    3'b110:  ctl.alu_ctrl = OR;
                    3'b111:  ctl.alu_ctrl = AND;
                    default: ctl.xcpt = UNDEF_INSTR;
                endcase
            end
            default: begin
                ctl.alu_ctrl = ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

/* core/exec_unit.sv */
`default_nettype none

`include "brisc_params.svh"

module exec_unit (
    input  logic [31:0]             instr,
    input  logic [`BRISC_XLEN-1:0]  rs1_data,
    input  logic [`BRISC_XLEN-1:0]  rs2_data,
    ctrl_if.exe                     ctl,
    output logic [`BRISC_XLEN-1:0]  imm,
    output logic [`BRISC_XLEN-1:0]  alu_result,
    output logic                    zero
);
    import brisc_pkg::*;

    logic [`BRISC_XLEN-1:0] operand_b;

    // immediate formats, all sign-extended from instr[31]
    always_comb begin
        case (ctl.imm_src)
            I_IMM: begin
                imm = {{(`BRISC_XLEN-12){instr[31]}}, instr[31:20]};
            end
            S_IMM: begin
                imm = {{(`BRISC_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            B_IMM: begin
                imm = {{(`BRISC_XLEN-13){instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            J_IMM: begin
                imm = {{(`BRISC_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    assign operand_b = (ctl.alu_src == FROM_IMM) ? imm : rs2_data;

    always_comb begin
        case (ctl.alu_ctrl)
            ADD:     alu_result = rs1_data + operand_b;
            SUB:     alu_result = rs1_data - operand_b;
            OR:      alu_result = rs1_data | operand_b;
            AND:     alu_result = rs1_data & operand_b;
            default: alu_result = rs1_data + operand_b;
        endcase
    end

    // beq resolves on equality through the subtract
    assign zero = (alu_result == '0);

endmodule

`default_nettype wire

/* core/pc_unit.sv */
`default_nettype none

`include "brisc_params.svh"

module pc_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    ctrl_if.seq                      ctl,
    input  logic                     zero,
    input  logic [`BRISC_XLEN-1:0]   imm,
    output logic [`BRISC_XLEN-1:0]   pc,
    output logic [`BRISC_XLEN-1:0]   pc_plus4,
    output logic                     halted
);
    import brisc_pkg::*;

    logic                   take_target;
    logic [`BRISC_XLEN-1:0] pc_next;

    assign pc_plus4    = pc + `BRISC_XLEN'(4);
    assign take_target = ctl.is_jump | (ctl.is_branch & zero);
    assign pc_next     = take_target ? pc + imm : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= `BRISC_XLEN'(`BRISC_RESET_PC);
            halted <= 1'b0;
        end else if (!halted) begin
            // pc stays on the faulting instruction
            if (ctl.xcpt == UNDEF_INSTR) begin
                halted <= 1'b1;
            end else begin
                pc <= pc_next;
            end
        end
    end

endmodule

`default_nettype wire

/* core/regfile.sv */
`default_nettype none

`include "brisc_params.svh"

module regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(`BRISC_NREGS)-1:0]   rs1_addr,
    input  logic [$clog2(`BRISC_NREGS)-1:0]   rs2_addr,
    input  logic [$clog2(`BRISC_NREGS)-1:0]   rd_addr,
    input  logic [`BRISC_XLEN-1:0]            rd_data,
    input  logic                              rd_we,
    output logic [`BRISC_XLEN-1:0]            rs1_data,
    output logic [`BRISC_XLEN-1:0]            rs2_data
);

    logic [`BRISC_XLEN-1:0] regs [`BRISC_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BRISC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* testbench/brisc_props.sv */
`default_nettype none

`include "brisc_params.svh"

module brisc_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   dmem_write,
    input logic [3:0]             dmem_be,
    input logic                   halted,
    input logic [`BRISC_XLEN-1:0] pc
);
    timeunit 1ns;
    timeprecision 1ps;

    int violations = 0;

    // a store always enables at least one lane
    store_lanes_a: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_write |-> dmem_be != 4'b0000)
        else begin
            violations++;
            $error("store issued with all byte enables low");
        end

    halted_store_a: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !dmem_write)
        else begin
            violations++;
            $error("store issued while the core is halted");
        end

    // pc stays on the faulting instruction
    halted_pc_a: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> $stable(pc))
        else begin
            violations++;
            $error("pc moved while the core is halted");
        end

    pc_align_a: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else begin
            violations++;
            $error("pc is not word aligned");
        end

endmodule

`default_nettype wire

/* testbench/brisc_tb.sv */
`default_nettype none

`include "brisc_params.svh"

module brisc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_be;
    logic        dmem_write;
    logic [31:0] dmem_rdata;
    logic        halted;
    logic [31:0] pc;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_be [$];
    logic [31:0] halt_pc;
    int          prog_lines;
    int          store_idx;
    int          limit_cycles;

    brisc_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .halted     (halted),
        .pc         (pc)
    );

    bind brisc_top brisc_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_write (dmem_write),
        .dmem_be    (dmem_be),
        .halted     (halted),
        .pc         (pc)
    );

    // both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    endtask

    task automatic load_testdata();
        int          fd;
        int          n;
        byte         tag;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        string       rest;
        fd = $fopen("testbench/brisc_testdata.txt", "r");
        assert (fd != 0) else abort_run("cannot open testbench/brisc_testdata.txt");
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "I": begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    assert (n == 2) else abort_run("incomplete I line in the test data file");
                    imem[addr[7:2]] = data;
                    prog_lines++;
                end
                "M": begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    assert (n == 2) else abort_run("incomplete M line in the test data file");
                    dmem[addr[9:2]] = data;
                end
                "S": begin
                    n = $fscanf(fd, "%h %h %h", addr, data, be);
                    assert (n == 3) else abort_run("incomplete S line in the test data file");
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                    exp_be.push_back(be);
                end
                "H": begin
                    n = $fscanf(fd, "%h", halt_pc);
                    assert (n == 1) else abort_run("incomplete H line in the test data file");
                end
                default: begin
                    assert (tag == "#") else abort_run("unknown tag in the test data file");
                end
            endcase
            // rest of the line, trailing comments included
            n = $fgets(rest, fd);
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic check_reset_state();
        assert (pc == 32'(`BRISC_RESET_PC))
            else report_mismatch("pc", 32'(`BRISC_RESET_PC), pc);
        assert (halted == 1'b0) else abort_run("halted is still set after reset");
    endtask

    // stores commit on the edge that retires them
    always @(posedge clk) begin
        logic [31:0] mask;
        if (rst_n && dmem_write) begin
            assert (store_idx < exp_addr.size())
                else abort_run("store committed after the expected trace was complete");
            for (int b = 0; b < 4; b++) begin
                mask[8*b +: 8] = {8{exp_be[store_idx][b]}};
                if (dmem_be[b]) begin
                    dmem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                end
            end
            assert (dmem_addr == exp_addr[store_idx])
                else report_mismatch("dmem_addr", exp_addr[store_idx], dmem_addr);
            assert (dmem_be == exp_be[store_idx])
                else report_mismatch("dmem_be", 32'(exp_be[store_idx]), 32'(dmem_be));
            assert ((dmem_wdata & mask) == (exp_data[store_idx] & mask))
                else report_mismatch("dmem_wdata", exp_data[store_idx] & mask,
                                     dmem_wdata & mask);
            store_idx++;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("timeout: core did not halt");
    end

    // failures of the bound checker end the run too
    initial begin
        wait (UUT.u_props.violations != 0);
        abort_run("property check failed in the bound checker");
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        store_idx    = 0;
        prog_lines   = 0;
        limit_cycles = 0;
        for (int i = 0; i < 64; i++) begin
            // opcode 0 is undefined, so stray fetches halt
            imem[i] = 32'(i) << 7;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd00d0000 | 32'(i);
        end
        load_testdata();
        limit_cycles = 16 * (prog_lines + exp_addr.size()) + 50;

        apply_reset();
        check_reset_state();
        wait (store_idx == 1);
        // second reset in the middle of the program
        apply_reset();
        check_reset_state();
        store_idx = 0;

        wait (halted === 1'b1);
        @(negedge clk);
        assert (store_idx == exp_addr.size())
            else abort_run("halted before all expected stores");
        // idle a little so a late store or a moving pc gets caught
        repeat (4) @(negedge clk);
        assert (pc == halt_pc) else report_mismatch("pc", halt_pc, pc);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/brisc_testdata.txt */
# I addr instr | M addr word | S addr data byte_enables | H halt_pc, all hex
I 00 10002083 # lw   x1, 0x100(x0)
I 04 10500103 # lb   x2, 0x105(x0)
I 08 0f000193 # addi x3, x0, 0xf0
I 0c 00308233 # add  x4, x1, x3
I 10 403082b3 # sub  x5, x1, x3
I 14 00316333 # or   x6, x2, x3
I 18 0060f3b3 # and  x7, x1, x6
I 1c 00f16413 # ori  x8, x2, 0xf
I 20 0ff0f493 # andi x9, x1, 0xff
I 24 20402023 # sw   x4, 0x200(x0)
I 28 20802223 # sw   x8, 0x204(x0)
I 2c 20500423 # sb   x5, 0x208(x0)
I 30 206004a3 # sb   x6, 0x209(x0)
I 34 20700523 # sb   x7, 0x20a(x0)
I 38 209005a3 # sb   x9, 0x20b(x0)
I 3c 00308463 # beq  x1, x3, +8 not taken
I 40 00000463 # beq  x0, x0, +8 taken
I 44 20102623 # sw   x1, 0x20c(x0) skipped
I 48 0080056f # jal  x10, +8
I 4c 20102623 # sw   x1, 0x20c(x0) skipped
I 50 20a02623 # sw   x10, 0x20c(x0)
I 54 ffffffff # undefined
M 100 12345678
M 104 00008000
S 200 12345768 f
S 204 ffffff8f f
S 208 88888888 1
S 209 f0f0f0f0 2
S 20a 70707070 4
S 20b 78787878 8
S 20c 0000004c f
H 54

/* verilog/brisc_top.sv */
`default_nettype none

`include "brisc_params.svh"

module brisc_top (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [31:0]              imem_addr,
    input  logic [31:0]              imem_rdata,
    output logic [`BRISC_XLEN-1:0]   dmem_addr,
    output logic [`BRISC_XLEN-1:0]   dmem_wdata,
    output logic [3:0]               dmem_be,
    output logic                     dmem_write,
    input  logic [`BRISC_XLEN-1:0]   dmem_rdata,
    output logic                     halted,
    output logic [`BRISC_XLEN-1:0]   pc
);
    import brisc_pkg::*;

    opcode_e                opcode;
    logic [`BRISC_XLEN-1:0] rs1_data;
    logic [`BRISC_XLEN-1:0] rs2_data;
    logic [`BRISC_XLEN-1:0] imm;
    logic [`BRISC_XLEN-1:0] alu_result;
    logic                   zero;
    logic [`BRISC_XLEN-1:0] pc_plus4;
    logic [`BRISC_XLEN-1:0] rd_data;
    logic                   rd_we;

    ctrl_if ctl_bus ();

    assign imem_addr = pc;
    assign opcode    = opcode_e'(imem_rdata[6:0]);
    assign dmem_addr = alu_result;

    ctrl u_ctrl (
        .funct3 (imem_rdata[14:12]),
        .funct7 (imem_rdata[31:25]),
        .opcode (opcode),
        .ctl    (ctl_bus.dec)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (imem_rdata[19:15]),
        .rs2_addr (imem_rdata[24:20]),
        .rd_addr  (imem_rdata[11:7]),
        .rd_data  (rd_data),
        .rd_we    (rd_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec_unit (
        .instr      (imem_rdata),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ctl        (ctl_bus.exe),
        .imm        (imm),
        .alu_result (alu_result),
        .zero       (zero)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (ctl_bus.seq),
        .zero     (zero),
        .imm      (imm),
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .halted   (halted)
    );

    lsu u_lsu (
        .ctl        (ctl_bus.mem),
        .halted     (halted),
        .xcpt_now   (ctl_bus.xcpt),
        .addr       (alu_result),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .pc_plus4   (pc_plus4),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_write (dmem_write),
        .rd_data    (rd_data),
        .rd_we      (rd_we)
    );

endmodule

`default_nettype wire

/* verilog/lsu.sv */
`default_nettype none

`include "brisc_params.svh"

module lsu (
    ctrl_if.mem                      ctl,
    input  logic                     halted,
    input  brisc_pkg::xcpt_e         xcpt_now,
    input  logic [`BRISC_XLEN-1:0]   addr,
    input  logic [`BRISC_XLEN-1:0]   rs2_data,
    input  logic [`BRISC_XLEN-1:0]   alu_result,
    input  logic [`BRISC_XLEN-1:0]   pc_plus4,
    input  logic [`BRISC_XLEN-1:0]   dmem_rdata,
    output logic [`BRISC_XLEN-1:0]   dmem_wdata,
    output logic [3:0]               dmem_be,
    output logic                     dmem_write,
    output logic [`BRISC_XLEN-1:0]   rd_data,
    output logic                     rd_we
);
    import brisc_pkg::*;

    logic                   blocked;
    logic [7:0]             load_byte;
    logic [`BRISC_XLEN-1:0] load_data;

    // store lane placement
    always_comb begin
        if (ctl.data_size == B) begin
            dmem_wdata = {4{rs2_data[7:0]}};
            dmem_be    = 4'b0001 << addr[1:0];
        end else begin
            dmem_wdata = rs2_data;
            dmem_be    = 4'b1111;
        end
    end

    assign load_byte = dmem_rdata[8*addr[1:0] +: 8];
    assign load_data = (ctl.data_size == B) ?
                       {{(`BRISC_XLEN-8){load_byte[7]}}, load_byte} : dmem_rdata;

    always_comb begin
        case (ctl.result_src)
            FROM_MEM:     rd_data = load_data;
            FROM_PC_NEXT: rd_data = pc_plus4;
            default:      rd_data = alu_result;
        endcase
    end

    // no architectural writes from a faulting or halted core
    assign blocked    = halted | (xcpt_now == UNDEF_INSTR);
    assign dmem_write = ctl.mem_write & ~blocked;
    assign rd_we      = ctl.reg_write & ~blocked;

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/brisc_pkg.sv
common/ctrl_if.sv
core/ctrl.sv
core/exec_unit.sv
core/regfile.sv
core/pc_unit.sv
verilog/lsu.sv
verilog/brisc_top.sv
testbench/brisc_props.sv
testbench/brisc_tb.sv
